// File: alu_iq.f
src/ooo_pkg.sv
src/iq_alloc_ctrl.sv
src/iq_payload_store.sv
src/operand_wakeup.sv
src/age_select.sv
src/alu_exec.sv
src/alu_iq.sv
tests/tb_alu_iq.sv

// File: tests/tb_alu_iq.sv
module tb_alu_iq;
    timeunit 1ns;
    timeprecision 100ps;

    import ooo_pkg::*;

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 3;
    // rough cycle budget of each test, summed in test order
    localparam int TEST_CYCLES    = 10 + 14 + 8 + 20 + 32 + 18;
    localparam int MARGIN_CYCLES  = 50;
    localparam int RESULT_TIMEOUT = 20;
    localparam int QUIET_CYCLES   = 6;
    localparam logic [31:0] LFSR_SEED = 32'hbc9b_311f;

    logic                        clk;
    logic                        rst_n_i;
    logic                        flush_i;
    logic    [IQ_LANES-1:0]      p_valid_i;
    alu_op_e [IQ_LANES-1:0]      p_op_i;
    rob_id_t [IQ_LANES-1:0]      p_dst_rid_i;
    rob_id_t [IQ_LANES-1:0][1:0] p_src_rid_i;
    logic    [IQ_LANES-1:0][1:0] p_src_ready_i;
    word_t   [IQ_LANES-1:0][1:0] p_src_data_i;
    word_t   [IQ_LANES-1:0]      p_imm_i;
    logic    [IQ_LANES-1:0]      p_use_imm_i;
    logic    [IQ_LANES-1:0]      iq_ready_o;
    logic    [1:0]               wkup_valid_i;
    rob_id_t [1:0]               wkup_rid_i;
    word_t   [1:0]               wkup_data_i;
    logic    [IQ_LANES-1:0]      wkup_valid_o;
    rob_id_t [IQ_LANES-1:0]      wkup_rid_o;
    word_t   [IQ_LANES-1:0]      wkup_data_o;

    logic [31:0] lfsr_state;
    int          checks;
    int          errors;
    int          errors_at_start;

    alu_iq i_alu_iq (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .p_valid_i     (p_valid_i),
        .p_op_i        (p_op_i),
        .p_dst_rid_i   (p_dst_rid_i),
        .p_src_rid_i   (p_src_rid_i),
        .p_src_ready_i (p_src_ready_i),
        .p_src_data_i  (p_src_data_i),
        .p_imm_i       (p_imm_i),
        .p_use_imm_i   (p_use_imm_i),
        .iq_ready_o    (iq_ready_o),
        .wkup_valid_i  (wkup_valid_i),
        .wkup_rid_i    (wkup_rid_i),
        .wkup_data_i   (wkup_data_i),
        .wkup_valid_o  (wkup_valid_o),
        .wkup_rid_o    (wkup_rid_o),
        .wkup_data_o   (wkup_data_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////
    // stimulus and reference model
    //////////////////////////////

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic word_t rand_word();
        word_t v;
        v = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            // differing signs decide alone, otherwise plain magnitude
            default: return (a[31] != b[31]) ? word_t'(a[31]) : word_t'(a < b);
        endcase
    endfunction

    //////////////////////////////
    // checks
    //////////////////////////////

    task automatic report_failure(input string msg);
        errors++;
        $display("error: %s", msg);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_rid(input string name, input rob_id_t got, input rob_id_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%02h, expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_cycles(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            report_failure($sformatf("%s came after %0d cycles instead of %0d", what, got, exp));
        end
    endtask

    //////////////////////////////
    // drivers
    //////////////////////////////

    task automatic init_inputs();
        clk           = 1'b0;
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        p_valid_i     = '0;
        p_dst_rid_i   = '0;
        p_src_rid_i   = '0;
        p_src_ready_i = '0;
        p_src_data_i  = '0;
        p_imm_i       = '0;
        p_use_imm_i   = '0;
        wkup_valid_i  = '0;
        wkup_rid_i    = '0;
        wkup_data_i   = '0;
        for (int l = 0; l < IQ_LANES; l++) begin
            p_op_i[l] = ALU_ADD;
        end
    endtask

    // called on a falling edge, taken at the next rising edge
    task automatic load_lane(input int lane, input alu_op_e op, input rob_id_t dst,
                             input rob_id_t rid_a, input logic rdy_a, input word_t data_a,
                             input rob_id_t rid_b, input logic rdy_b, input word_t data_b,
                             input word_t imm, input logic use_imm);
        if (!iq_ready_o[lane]) begin
            report_failure($sformatf("lane %0d not ready for dispatch of rid 0x%02h", lane, dst));
        end else begin
            p_valid_i[lane]        = 1'b1;
            p_op_i[lane]           = op;
            p_dst_rid_i[lane]      = dst;
            p_src_rid_i[lane]      = {rid_b, rid_a};
            p_src_ready_i[lane]    = {rdy_b, rdy_a};
            p_src_data_i[lane][0]  = data_a;
            p_src_data_i[lane][1]  = data_b;
            p_imm_i[lane]          = imm;
            p_use_imm_i[lane]      = use_imm;
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        p_valid_i = '0;
    endtask

    task automatic ext_wakeup(input int bus, input rob_id_t rid, input word_t data);
        wkup_valid_i[bus] = 1'b1;
        wkup_rid_i[bus]   = rid;
        wkup_data_i[bus]  = data;
        @(negedge clk);
        wkup_valid_i[bus] = 1'b0;
    endtask

    // cycles is 1 when the result is already on the bus
    task automatic expect_result(input int lane, input rob_id_t rid, input word_t data,
                                 output int cycles);
        cycles = 1;
        while (wkup_valid_o[lane] !== 1'b1 && cycles < RESULT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (wkup_valid_o[lane] !== 1'b1) begin
            report_failure($sformatf("no result on lane %0d for rid 0x%02h", lane, rid));
        end else begin
            check_rid($sformatf("wkup_rid_o[%0d]", lane), wkup_rid_o[lane], rid);
            check_word($sformatf("wkup_data_o[%0d]", lane), wkup_data_o[lane], data);
        end
    endtask

    task automatic begin_test();
        errors_at_start = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_at_start);
        end
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    task automatic test_independent();
        word_t a;
        word_t b;
        int    cyc;
        begin_test();
        for (int l = 0; l < IQ_LANES; l++) begin
            a = rand_word();
            b = rand_word();
            load_lane(l, ALU_ADD, rob_id_t'(1 + l), 0, 1'b1, a, 0, 1'b1, b, '0, 1'b0);
            next_cycle();
            expect_result(l, rob_id_t'(1 + l), alu_model(ALU_ADD, a, b), cyc);
            check_cycles($sformatf("lane %0d result", l), cyc, 2);
            @(negedge clk);
        end
        end_test("independent");
    endtask

    task automatic test_oldest_first();
        word_t b [4];
        word_t w;
        int    cyc;
        begin_test();
        // all four share a source that is still in flight elsewhere
        for (int i = 0; i < 4; i++) begin
            b[i] = rand_word();
            load_lane(1, ALU_ADD, rob_id_t'(8 + i), 20, 1'b0, '0, 0, 1'b1, b[i], '0, 1'b0);
            next_cycle();
        end
        check_flag("iq_ready_o[1]", iq_ready_o[1], 1'b0);
        w = rand_word();
        ext_wakeup(0, 20, w);
        for (int i = 0; i < 4; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            expect_result(1, rob_id_t'(8 + i), alu_model(ALU_ADD, w, b[i]), cyc);
            check_cycles($sformatf("result %0d of the group", i), cyc, 1);
        end
        @(negedge clk);
        end_test("oldest_first");
    endtask

    task automatic test_wakeup_chain();
        word_t a;
        word_t b;
        word_t c;
        int    cyc;
        begin_test();
        a = rand_word();
        b = rand_word();
        c = rand_word();
        // consumer on lane 1 waits on the lane 0 producer
        load_lane(0, ALU_ADD, 12, 0, 1'b1, a, 0, 1'b1, b, '0, 1'b0);
        load_lane(1, ALU_XOR, 13, 12, 1'b0, '0, 0, 1'b1, c, '0, 1'b0);
        next_cycle();
        expect_result(0, 12, alu_model(ALU_ADD, a, b), cyc);
        check_cycles("producer result", cyc, 2);
        @(negedge clk);
        expect_result(1, 13, alu_model(ALU_XOR, alu_model(ALU_ADD, a, b), c), cyc);
        check_cycles("dependent result", cyc, 1);
        @(negedge clk);
        end_test("wakeup_chain");
    endtask

    task automatic test_back_pressure();
        word_t b [4];
        word_t x;
        word_t y;
        word_t w;
        int    cyc;
        begin_test();
        for (int i = 0; i < 4; i++) begin
            b[i] = rand_word();
            load_lane(0, ALU_SUB, rob_id_t'(14 + i), 21, 1'b0, '0, 0, 1'b1, b[i], '0, 1'b0);
            next_cycle();
        end
        check_flag("iq_ready_o[0]", iq_ready_o[0], 1'b0);
        check_flag("iq_ready_o[1]", iq_ready_o[1], 1'b1);
        // other lane keeps working
        x = rand_word();
        y = rand_word();
        load_lane(1, ALU_AND, 18, 0, 1'b1, x, 0, 1'b1, y, '0, 1'b0);
        next_cycle();
        expect_result(1, 18, alu_model(ALU_AND, x, y), cyc);
        check_cycles("lane 1 result", cyc, 2);
        @(negedge clk);
        check_flag("iq_ready_o[0]", iq_ready_o[0], 1'b0);
        w = rand_word();
        ext_wakeup(1, 21, w);
        check_flag("iq_ready_o[0]", iq_ready_o[0], 1'b1);
        for (int i = 0; i < 4; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            expect_result(0, rob_id_t'(14 + i), alu_model(ALU_SUB, w, b[i]), cyc);
            check_cycles($sformatf("drained result %0d", i), cyc, 1);
        end
        @(negedge clk);
        end_test("back_pressure");
    endtask

    task automatic test_all_ops();
        alu_op_e op;
        word_t   a;
        word_t   b;
        word_t   imm;
        int      cyc;
        begin_test();
        // lane 0 takes the register operand, lane 1 the immediate
        for (int i = 0; i < 8; i++) begin
            op  = alu_op_e'(i);
            a   = rand_word();
            b   = rand_word();
            imm = rand_word();
            load_lane(0, op, 24, 0, 1'b1, a, 0, 1'b1, b, imm, 1'b0);
            load_lane(1, op, 25, 0, 1'b1, a, 0, 1'b1, b, imm, 1'b1);
            next_cycle();
            expect_result(0, 24, alu_model(op, a, b), cyc);
            check_cycles($sformatf("%s register result", op.name()), cyc, 2);
            expect_result(1, 25, alu_model(op, a, imm), cyc);
            check_cycles($sformatf("%s immediate result", op.name()), cyc, 1);
            @(negedge clk);
        end
        end_test("all_ops");
    endtask

    task automatic test_flush();
        word_t a;
        word_t b;
        int    cyc;
        begin_test();
        a = rand_word();
        b = rand_word();
        // lane 0 fills up behind a source that has not arrived yet
        for (int i = 0; i < 4; i++) begin
            load_lane(0, ALU_OR, rob_id_t'(26 + i), 22, 1'b0, '0, 0, 1'b1, a, '0, 1'b0);
            next_cycle();
        end
        check_flag("iq_ready_o[0]", iq_ready_o[0], 1'b0);
        load_lane(1, ALU_ADD, 30, 0, 1'b1, a, 0, 1'b1, b, '0, 1'b0);
        next_cycle();
        // lane 1 is issuing right now
        flush_i = 1'b1;
        @(negedge clk);
        flush_i = 1'b0;
        for (int l = 0; l < IQ_LANES; l++) begin
            check_flag($sformatf("iq_ready_o[%0d]", l), iq_ready_o[l], 1'b1);
            check_flag($sformatf("wkup_valid_o[%0d]", l), wkup_valid_o[l], 1'b0);
        end
        // would wake the flushed lane 0 entries
        wkup_valid_i[0] = 1'b1;
        wkup_rid_i[0]   = 22;
        wkup_data_i[0]  = rand_word();
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            wkup_valid_i = '0;
            for (int l = 0; l < IQ_LANES; l++) begin
                check_flag($sformatf("wkup_valid_o[%0d]", l), wkup_valid_o[l], 1'b0);
            end
        end
        load_lane(0, ALU_ADD, 31, 0, 1'b1, a, 0, 1'b1, b, '0, 1'b0);
        next_cycle();
        expect_result(0, 31, alu_model(ALU_ADD, a, b), cyc);
        check_cycles("result after flush", cyc, 2);
        @(negedge clk);
        end_test("flush");
    endtask

    //////////////////////////////
    // run control
    //////////////////////////////

    initial begin
        #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("error: watchdog expired at %0t", $time);
        $display("sim failed");
        $finish;
    end

    initial begin
        checks     = 0;
        errors     = 0;
        lfsr_state = LFSR_SEED;
        init_inputs();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        test_independent();
        test_oldest_first();
        test_wakeup_chain();
        test_back_pressure();
        test_all_ops();
        test_flush();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: src/alu_iq.sv
module alu_iq (
    input  logic                                              clk,
    input  logic                                              rst_n_i,
    input  logic                                              flush_i,
    input  logic            [ooo_pkg::IQ_LANES-1:0]           p_valid_i,
    input  ooo_pkg::alu_op_e [ooo_pkg::IQ_LANES-1:0]          p_op_i,
    input  ooo_pkg::rob_id_t [ooo_pkg::IQ_LANES-1:0]          p_dst_rid_i,
    input  ooo_pkg::rob_id_t [ooo_pkg::IQ_LANES-1:0][1:0]     p_src_rid_i,
    input  logic            [ooo_pkg::IQ_LANES-1:0][1:0]      p_src_ready_i,
    input  ooo_pkg::word_t  [ooo_pkg::IQ_LANES-1:0][1:0]      p_src_data_i,
    input  ooo_pkg::word_t  [ooo_pkg::IQ_LANES-1:0]           p_imm_i,
    input  logic            [ooo_pkg::IQ_LANES-1:0]           p_use_imm_i,
    output logic            [ooo_pkg::IQ_LANES-1:0]           iq_ready_o,
    input  logic            [1:0]                             wkup_valid_i,
    input  ooo_pkg::rob_id_t [1:0]                            wkup_rid_i,
    input  ooo_pkg::word_t  [1:0]                             wkup_data_i,
    output logic            [ooo_pkg::IQ_LANES-1:0]           wkup_valid_o,
    output ooo_pkg::rob_id_t [ooo_pkg::IQ_LANES-1:0]          wkup_rid_o,
    output ooo_pkg::word_t  [ooo_pkg::IQ_LANES-1:0]           wkup_data_o
);
    import ooo_pkg::*;

    logic [IQ_LANES-1:0][IQ_LANE_SIZE-1:0]                   alloc_oh;
    logic [IQ_LANES-1:0][IQ_LANE_SIZE-1:0]                   entry_valid;
    logic [IQ_LANES-1:0][IQ_LANE_SIZE-1:0]                   entry_ready;
    logic [IQ_LANES-1:0][IQ_LANE_SIZE-1:0]                   grant_oh;
    logic [IQ_LANES-1:0][IQ_LANE_SIZE-1:0][AGING_LENGTH-1:0] age;

    // external buses sit low, alu results high
    logic    [WKUP_BUSES-1:0] bus_valid;
    rob_id_t [WKUP_BUSES-1:0] bus_rid;
    word_t   [WKUP_BUSES-1:0] bus_data;

    assign bus_valid = {wkup_valid_o, wkup_valid_i};
    assign bus_rid   = {wkup_rid_o, wkup_rid_i};
    assign bus_data  = {wkup_data_o, wkup_data_i};

    iq_alloc_ctrl i_iq_alloc_ctrl (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .p_valid_i     (p_valid_i),
        .grant_oh_i    (grant_oh),
        .iq_ready_o    (iq_ready_o),
        .alloc_oh_o    (alloc_oh),
        .entry_valid_o (entry_valid),
        .age_o         (age)
    );

    for (genvar l = 0; l < IQ_LANES; l++) begin : g_lane
        iq_static_t                         wr_static;
        iq_static_t                         entry_static [IQ_LANE_SIZE];
        operand_pair_t [IQ_LANE_SIZE-1:0]   entry_ops;
        iq_static_t                         issue_static;
        operand_pair_t                      issue_ops;

        assign wr_static = '{op: p_op_i[l], dst_rid: p_dst_rid_i[l],
                             imm: p_imm_i[l], use_imm: p_use_imm_i[l]};

        iq_payload_store #(.payload_t(iq_static_t)) i_static_store (
            .clk          (clk),
            .alloc_oh_i   (alloc_oh[l]),
            .wr_payload_i (wr_static),
            .payload_o    (entry_static)
        );

        operand_wakeup i_operand_wakeup (
            .clk           (clk),
            .rst_n_i       (rst_n_i),
            .alloc_oh_i    (alloc_oh[l]),
            .p_src_rid_i   (p_src_rid_i[l]),
            .p_src_ready_i (p_src_ready_i[l]),
            .p_src_data_i  (p_src_data_i[l]),
            .entry_valid_i (entry_valid[l]),
            .wkup_valid_i  (bus_valid),
            .wkup_rid_i    (bus_rid),
            .wkup_data_i   (bus_data),
            .entry_ready_o (entry_ready[l]),
            .operands_o    (entry_ops)
        );

        age_select i_age_select (
            .entry_ready_i (entry_ready[l]),
            .age_i         (age[l]),
            .grant_oh_o    (grant_oh[l])
        );

        // granted entry to the alu
        always_comb begin
            issue_static = '0;
            issue_ops    = '0;
            for (int e = 0; e < IQ_LANE_SIZE; e++) begin
                if (grant_oh[l][e]) begin
                    issue_static = entry_static[e];
                    issue_ops    = entry_ops[e];
                end
            end
        end

        alu_exec i_alu_exec (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .flush_i     (flush_i),
            .issue_i     (grant_oh[l]),
            .static_i    (issue_static),
            .operands_i  (issue_ops),
            .res_valid_o (wkup_valid_o[l]),
            .res_rid_o   (wkup_rid_o[l]),
            .res_data_o  (wkup_data_o[l])
        );
    end

endmodule

// File: src/alu_exec.sv
module alu_exec (
    input  logic                                 clk,
    input  logic                                 rst_n_i,
    input  logic                                 flush_i,
    input  logic [ooo_pkg::IQ_LANE_SIZE-1:0]     issue_i,
    input  ooo_pkg::iq_static_t                  static_i,
    input  ooo_pkg::operand_pair_t               operands_i,
    output logic                                 res_valid_o,
    output ooo_pkg::rob_id_t                     res_rid_o,
    output ooo_pkg::word_t                       res_data_o
);
    import ooo_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t result;
    logic  fire;

    // one-hot grant from the picker, any bit issues
    assign fire = |issue_i;

    assign op_a = operands_i.rs1;
    assign op_b = static_i.use_imm ? static_i.imm : operands_i.rs2;

    always_comb begin
        case (static_i.op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            // shift amount from the low five bits
            ALU_SLL: result = op_a << op_b[4:0];
            ALU_SRL: result = op_a >> op_b[4:0];
            ALU_SLT: result = {31'd0, $signed(op_a) < $signed(op_b)};
            default: result = '0;
        endcase
    end

    //////////////////////////////
    // result register
    //////////////////////////////

    // flush drops whatever is in flight
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            res_rid_o  <= static_i.dst_rid;
            res_data_o <= result;
        end
    end

endmodule

// File: src/age_select.sv
module age_select (
    input  logic [ooo_pkg::IQ_LANE_SIZE-1:0]                              entry_ready_i,
    input  logic [ooo_pkg::IQ_LANE_SIZE-1:0][ooo_pkg::AGING_LENGTH-1:0]   age_i,
    output logic [ooo_pkg::IQ_LANE_SIZE-1:0]                              grant_oh_o
);
    import ooo_pkg::*;

    localparam int IDX_W = $clog2(IQ_LANE_SIZE);

    // tree nodes, level results overwrite the low slots
    logic [IQ_LANE_SIZE-1:0]                   node_vld;
    logic [IQ_LANE_SIZE-1:0][AGING_LENGTH-1:0] node_age;
    logic [IQ_LANE_SIZE-1:0][IDX_W-1:0]        node_idx;

    // flat scan of the entries, kept apart from the tree
    logic                    chk_found;
    logic                    chk_beaten;
    logic [AGING_LENGTH-1:0] chk_age;

    always_comb begin
        for (int e = 0; e < IQ_LANE_SIZE; e++) begin
            node_vld[e] = entry_ready_i[e];
            node_age[e] = age_i[e];
            node_idx[e] = IDX_W'(e);
        end
        for (int w = IQ_LANE_SIZE / 2; w >= 1; w = w / 2) begin
            for (int n = 0; n < w; n++) begin
                // upper half wins only when strictly older
                if (node_vld[2*n+1] && (!node_vld[2*n] || node_age[2*n+1] > node_age[2*n])) begin
                    node_vld[n] = 1'b1;
                    node_age[n] = node_age[2*n+1];
                    node_idx[n] = node_idx[2*n+1];
                end else begin
                    node_vld[n] = node_vld[2*n];
                    node_age[n] = node_age[2*n];
                    node_idx[n] = node_idx[2*n];
                end
            end
        end
        grant_oh_o = '0;
        if (node_vld[0]) begin
            grant_oh_o[node_idx[0]] = 1'b1;
        end
    end

    // a ready entry beats the grant when older, or equally old at a lower index
    always_comb begin
        chk_found  = 1'b0;
        chk_beaten = 1'b0;
        chk_age    = '0;
        for (int e = 0; e < IQ_LANE_SIZE; e++) begin
            if (grant_oh_o[e]) begin
                chk_age = age_i[e];
            end
        end
        for (int e = 0; e < IQ_LANE_SIZE; e++) begin
            if (grant_oh_o[e]) begin
                chk_found = 1'b1;
            end else if (entry_ready_i[e]
                         && (age_i[e] > chk_age || (!chk_found && age_i[e] == chk_age))) begin
                chk_beaten = 1'b1;
            end
        end
    end

    // at most one grant, only to the oldest ready entry
    a_grant_oldest: assert final (
        $onehot0(grant_oh_o) && ((grant_oh_o & ~entry_ready_i) == '0)
        && ((grant_oh_o != '0) == (|entry_ready_i)) && !chk_beaten
    );

endmodule

// File: src/operand_wakeup.sv
module operand_wakeup (
    input  logic                                         clk,
    input  logic                                         rst_n_i,
    input  logic [ooo_pkg::IQ_LANE_SIZE-1:0]             alloc_oh_i,
    input  ooo_pkg::rob_id_t [1:0]                       p_src_rid_i,
    input  logic [1:0]                                   p_src_ready_i,
    input  ooo_pkg::word_t [1:0]                         p_src_data_i,
    input  logic [ooo_pkg::IQ_LANE_SIZE-1:0]             entry_valid_i,
    input  logic [ooo_pkg::WKUP_BUSES-1:0]               wkup_valid_i,
    input  ooo_pkg::rob_id_t [ooo_pkg::WKUP_BUSES-1:0]   wkup_rid_i,
    input  ooo_pkg::word_t [ooo_pkg::WKUP_BUSES-1:0]     wkup_data_i,
    output logic [ooo_pkg::IQ_LANE_SIZE-1:0]             entry_ready_o,
    output ooo_pkg::operand_pair_t [ooo_pkg::IQ_LANE_SIZE-1:0] operands_o
);
    import ooo_pkg::*;

    rob_id_t                       src_rid_q  [IQ_LANE_SIZE][2];
    word_t                         src_data_q [IQ_LANE_SIZE][2];
    logic [IQ_LANE_SIZE-1:0][1:0]  src_rdy_q;
    logic [IQ_LANE_SIZE-1:0][1:0]  wk_hit;
    word_t                         wk_data    [IQ_LANE_SIZE][2];
    logic [1:0]                    disp_hit;
    word_t                         disp_data  [2];

    function automatic logic bus_match(input rob_id_t rid);
        logic hit;
        hit = 1'b0;
        for (int b = 0; b < WKUP_BUSES; b++) begin
            hit |= wkup_valid_i[b] && (wkup_rid_i[b] == rid);
        end
        return hit;
    endfunction

    function automatic word_t bus_value(input rob_id_t rid);
        word_t val;
        val = '0;
        for (int b = 0; b < WKUP_BUSES; b++) begin
            if (wkup_valid_i[b] && wkup_rid_i[b] == rid) begin
                val = wkup_data_i[b];
            end
        end
        return val;
    endfunction

    //////////////////////////////
    // tag match
    //////////////////////////////

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            disp_hit[s]  = bus_match(p_src_rid_i[s]);
            disp_data[s] = bus_value(p_src_rid_i[s]);
        end
        for (int e = 0; e < IQ_LANE_SIZE; e++) begin
            for (int s = 0; s < 2; s++) begin
                wk_hit[e][s]  = bus_match(src_rid_q[e][s]);
                wk_data[e][s] = bus_value(src_rid_q[e][s]);
            end
            // a source woken this cycle bypasses straight to issue
            entry_ready_o[e] = entry_valid_i[e]
                             & (src_rdy_q[e][0] | wk_hit[e][0])
                             & (src_rdy_q[e][1] | wk_hit[e][1]);
            operands_o[e].rs1 = src_rdy_q[e][0] ? src_data_q[e][0] : wk_data[e][0];
            operands_o[e].rs2 = src_rdy_q[e][1] ? src_data_q[e][1] : wk_data[e][1];
        end
    end

    //////////////////////////////
    // capture
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            src_rdy_q <= '0;
        end else begin
            for (int e = 0; e < IQ_LANE_SIZE; e++) begin
                if (alloc_oh_i[e]) begin
                    src_rdy_q[e] <= p_src_ready_i | disp_hit;
                end else begin
                    src_rdy_q[e] <= src_rdy_q[e] | wk_hit[e];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int e = 0; e < IQ_LANE_SIZE; e++) begin
            for (int s = 0; s < 2; s++) begin
                if (alloc_oh_i[e]) begin
                    src_rid_q[e][s]  <= p_src_rid_i[s];
                    src_data_q[e][s] <= p_src_ready_i[s] ? p_src_data_i[s] : disp_data[s];
                end else if (!src_rdy_q[e][s] && wk_hit[e][s]) begin
                    src_data_q[e][s] <= wk_data[e][s];
                end
            end
        end
    end

    // a rob id is produced once, so no two buses share it
    for (genvar a = 0; a < WKUP_BUSES; a++) begin : g_bus_a
        for (genvar b = a + 1; b < WKUP_BUSES; b++) begin : g_bus_b
            a_unique_wkup_rid: assert property (
                @(posedge clk) disable iff (!rst_n_i)
                !(wkup_valid_i[a] && wkup_valid_i[b] && wkup_rid_i[a] == wkup_rid_i[b])
            );
        end
    end

endmodule

// File: src/iq_payload_store.sv
module iq_payload_store #(
    parameter type payload_t = logic [7:0]
) (
    input  logic                              clk,
    input  logic [ooo_pkg::IQ_LANE_SIZE-1:0]  alloc_oh_i,
    input  payload_t                          wr_payload_i,
    output payload_t                          payload_o [ooo_pkg::IQ_LANE_SIZE]
);
    import ooo_pkg::*;

    // one slot per entry, written once when the entry is taken
    payload_t mem_q [IQ_LANE_SIZE];

    always_ff @(posedge clk) begin
        for (int e = 0; e < IQ_LANE_SIZE; e++) begin
            if (alloc_oh_i[e]) begin
                mem_q[e] <= wr_payload_i;
            end
        end
    end

    // all slots visible, issue mux sits outside
    assign payload_o = mem_q;

endmodule

// File: src/iq_alloc_ctrl.sv
module iq_alloc_ctrl (
    input  logic clk,
    input  logic rst_n_i,
    input  logic flush_i,
    input  logic [ooo_pkg::IQ_LANES-1:0]                                 p_valid_i,
    input  logic [ooo_pkg::IQ_LANES-1:0][ooo_pkg::IQ_LANE_SIZE-1:0]      grant_oh_i,
    output logic [ooo_pkg::IQ_LANES-1:0]                                 iq_ready_o,
    output logic [ooo_pkg::IQ_LANES-1:0][ooo_pkg::IQ_LANE_SIZE-1:0]      alloc_oh_o,
    output logic [ooo_pkg::IQ_LANES-1:0][ooo_pkg::IQ_LANE_SIZE-1:0]      entry_valid_o,
    output logic [ooo_pkg::IQ_LANES-1:0][ooo_pkg::IQ_LANE_SIZE-1:0]
                 [ooo_pkg::AGING_LENGTH-1:0]                             age_o
);
    import ooo_pkg::*;

    logic [IQ_LANES-1:0][IQ_LANE_SIZE-1:0]                   valid_q;
    logic [IQ_LANES-1:0][IQ_LANE_SIZE-1:0][AGING_LENGTH-1:0] age_q;
    logic [IQ_LANES-1:0][IQ_LANE_SIZE-1:0]                   free_vec;
    logic [IQ_LANES-1:0][IQ_LANE_SIZE-1:0]                   lowest_free;

    //////////////////////////////
    // free entry search
    //////////////////////////////

    for (genvar l = 0; l < IQ_LANES; l++) begin : g_free
        assign free_vec[l]    = ~valid_q[l];
        // isolate the lowest set bit
        assign lowest_free[l] = free_vec[l] & (~free_vec[l] + 1'b1);
        assign iq_ready_o[l]  = |free_vec[l];
        assign alloc_oh_o[l]  = lowest_free[l] & {IQ_LANE_SIZE{p_valid_i[l]}};
    end

    assign entry_valid_o = valid_q;
    assign age_o         = age_q;

    //////////////////////////////
    // entry state
    //////////////////////////////

    // granted entries leave at the same edge they issue
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            valid_q <= '0;
        end else begin
            for (int l = 0; l < IQ_LANES; l++) begin
                valid_q[l] <= (valid_q[l] & ~grant_oh_i[l]) | alloc_oh_o[l];
            end
        end
    end

    // ages count up while the entry waits, stuck at all ones
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            age_q <= '0;
        end else begin
            for (int l = 0; l < IQ_LANES; l++) begin
                for (int e = 0; e < IQ_LANE_SIZE; e++) begin
                    if (alloc_oh_o[l][e]) begin
                        age_q[l][e] <= '0;
                    end else if (valid_q[l][e] && age_q[l][e] != '1) begin
                        age_q[l][e] <= age_q[l][e] + 1'b1;
                    end
                end
            end
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    for (genvar l = 0; l < IQ_LANES; l++) begin : g_chk
        // upstream holds while the lane is full
        a_no_dispatch_when_full: assert property (
            @(posedge clk) disable iff (!rst_n_i)
            p_valid_i[l] |-> iq_ready_o[l]
        );

        // picker may only grant live entries
        a_grant_valid_only: assert property (
            @(posedge clk) disable iff (!rst_n_i)
            (grant_oh_i[l] & ~valid_q[l]) == '0
        );
    end

endmodule

// File: src/ooo_pkg.sv
package ooo_pkg;

    //////////////////////////////
    // issue stage sizing
    //////////////////////////////

    // entries per lane, two lanes give eight in all
    localparam int IQ_LANE_SIZE = 4;
    localparam int IQ_LANES     = 2;

    // bits of each saturating age counter
    localparam int AGING_LENGTH = 4;

    // two external buses followed by the two alu result buses
    localparam int WKUP_BUSES   = 4;

    //////////////////////////////
    // basic types
    //////////////////////////////

    typedef logic [31:0] word_t;

    // reorder buffer id, also the result tag
    typedef logic [4:0] rob_id_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7  // signed compare
    } alu_op_e;

    //////////////////////////////
    // entry contents
    //////////////////////////////

    // fields fixed from dispatch to issue, 41 bits
    typedef struct packed {
        alu_op_e op;
        rob_id_t dst_rid;
        word_t   imm;
        logic    use_imm;
    } iq_static_t;

    // source operands handed to the alu
    typedef struct packed {
        word_t rs1;
        word_t rs2;
    } operand_pair_t;

endpackage
